// ==== bench/sdram_burst_model.sv ====
//////////////////////////////
// Behavioral burst SDRAM
// Sparse halfword memory, random beat stalls
//////////////////////////////
`include "l2_cache_consts.svh"

module sdram_burst_model (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    sdr_rd_req,
   input  logic                    sdr_wr_req,
   input  logic [`L2_AW-2:0]       sdr_addr,
   output logic [`L2_SDR_DW-1:0]   sdr_rdata,
   output logic                    sdr_r_vld,
   input  logic [`L2_SDR_DW-1:0]   sdr_wdata,
   output logic                    sdr_w_rdy
);
   timeunit 1ns;
   timeprecision 100ps;

   // Only halfwords that were written are stored
   logic [`L2_SDR_DW-1:0] mem [int];
   logic [`L2_SDR_DW-1:0] rdata_q = '0;
   logic                  r_vld_q = 1'b0;
   logic                  w_rdy_q = 1'b0;
   int                    beat = 0;

   assign sdr_rdata = rdata_q;
   assign sdr_r_vld = r_vld_q;
   assign sdr_w_rdy = w_rdy_q;

   // Unwritten halfword a holds a * 3 + 1
   function automatic logic [`L2_SDR_DW-1:0] read_half(input int a);
      if (mem.exists(a))
         return mem[a];
      return 16'(a * 3 + 1);
   endfunction

   // Roughly one beat in four is held back
   function automatic logic beat_allowed();
      return ($urandom % 4) != 0;
   endfunction

   always @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         beat = 0;
         rdata_q <= '0;
         r_vld_q <= 1'b0;
         w_rdy_q <= 1'b0;
      end else begin
         // Beats taken at this edge
         if (sdr_wr_req && w_rdy_q) begin
            mem[int'(sdr_addr) + beat] = sdr_wdata;
            beat = beat + 1;
         end
         if (sdr_rd_req && r_vld_q)
            beat = beat + 1;
         if (!sdr_rd_req && !sdr_wr_req)
            beat = 0;
         r_vld_q <= sdr_rd_req && beat < `L2_BURST_LEN && beat_allowed();
         w_rdy_q <= sdr_wr_req && beat < `L2_BURST_LEN && beat_allowed();
         rdata_q <= read_half(int'(sdr_addr) + beat);
      end
   end

endmodule

// ==== bench/tb_l2_cache.sv ====
//////////////////////////////
// L2 cache testbench
// Shadow memory, checks, watchdog
//////////////////////////////
`include "l2_cache_consts.svh"

module tb_l2_cache;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int clk_period = 8;
   // About 20 line bursts of under 60 cycles each, with wide margin
   localparam int watchdog_cycles = 4000;
   localparam int any_rsp = 0;
   localparam int want_hit = 1;
   localparam int want_miss = 2;

   logic                    clk = 1'b0;
   logic                    rst_n;
   logic                    cmd_valid;
   logic                    cmd_ready;
   logic [`L2_AW-1:0]       cmd_addr;
   logic [`L2_DW/8-1:0]     cmd_we_msk;
   logic [`L2_DW-1:0]       cmd_wdata;
   logic                    rsp_valid;
   logic                    rsp_ready;
   logic [`L2_DW-1:0]       rsp_rdata;
   logic                    flush_req;
   logic                    flush_busy;
   logic                    sdr_rd_req;
   logic                    sdr_wr_req;
   logic [`L2_AW-2:0]       sdr_addr;
   logic [`L2_SDR_DW-1:0]   sdr_rdata;
   logic                    sdr_r_vld;
   logic [`L2_SDR_DW-1:0]   sdr_wdata;
   logic                    sdr_w_rdy;

   // Bytes written by the bench, keyed by byte address
   logic [7:0]              shadow [int];
   int                      written_lines [$];
   int                      rd_bursts;
   int                      wr_bursts;
   int                      stall_cycles;
   logic [`L2_AW-2:0]       last_wr_addr;
   logic                    rd_q;
   logic                    wr_q;
   bit                      bp_mode;

   always #(clk_period / 2) clk = ~clk;

   l2_cache_top u_l2_cache_top (.*);

   sdram_burst_model u_sdram (.*);

   task automatic stop_run(input string why);
      $display("%s", why);
      $display("tests failed");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic check_val(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
      assert (got === exp) else
         stop_run($sformatf("ERR at %0d ns: %s got %h expected %h", $time, name, got, exp));
   endtask

   function automatic logic [7:0] shadow_byte(input int a);
      logic [15:0] half;
      half = 16'((a >> 1) * 3 + 1);
      if (shadow.exists(a))
         return shadow[a];
      return a[0] ? half[15:8] : half[7:0];
   endfunction

   function automatic logic [31:0] shadow_word(input int a);
      return {shadow_byte(a + 3), shadow_byte(a + 2), shadow_byte(a + 1), shadow_byte(a)};
   endfunction

   // Burst starts and held responses
   always @(posedge clk) begin
      if (!rst_n) begin
         rd_q <= 1'b0;
         wr_q <= 1'b0;
         rd_bursts <= 0;
         wr_bursts <= 0;
         stall_cycles <= 0;
      end else begin
         rd_q <= sdr_rd_req;
         wr_q <= sdr_wr_req;
         if (sdr_rd_req && !rd_q)
            rd_bursts <= rd_bursts + 1;
         if (sdr_wr_req && !wr_q) begin
            wr_bursts <= wr_bursts + 1;
            last_wr_addr <= sdr_addr;
         end
         if (rsp_valid && !rsp_ready)
            stall_cycles <= stall_cycles + 1;
      end
   end

   a_rsp_held: assert property (@(posedge clk) disable iff (!rst_n)
      rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_rdata) && !cmd_ready)
      else stop_run("response or cmd_ready changed while rsp_ready was low");

   a_flush_blocks: assert property (@(posedge clk) disable iff (!rst_n)
      flush_busy |-> !cmd_ready)
      else stop_run("cmd_ready was high during a flush");

   // One command, from valid to the response being taken
   task automatic run_cmd(input int addr, input logic [3:0] msk, input logic [31:0] wdata,
                          output logic [31:0] rdata, output int lat);
      int cyc;
      bit taken;
      cmd_valid <= 1'b1;
      cmd_addr <= addr[`L2_AW-1:0];
      cmd_we_msk <= msk;
      cmd_wdata <= wdata;
      do
         @(posedge clk);
      while (!cmd_ready);
      cmd_valid <= 1'b0;
      cyc = 0;
      lat = 0;
      taken = 1'b0;
      rdata = '0;
      while (!taken) begin
         if (bp_mode)
            rsp_ready <= ($urandom % 4 == 0);
         @(posedge clk);
         cyc++;
         if (rsp_valid && lat == 0)
            lat = cyc;
         if (rsp_valid && rsp_ready) begin
            taken = 1'b1;
            rdata = rsp_rdata;
         end
      end
      rsp_ready <= 1'b1;
   endtask

   task automatic write_cmd(input int addr, input logic [3:0] msk, input logic [31:0] data);
      logic [31:0] unused;
      int lat;
      run_cmd(addr, msk, data, unused, lat);
      for (int i = 0; i < 4; i++) begin
         if (msk[i])
            shadow[addr + i] = data[8*i +: 8];
      end
      written_lines.push_back(addr & ~63);
   endtask

   task automatic read_check(input int addr, input int kind);
      logic [31:0] got;
      int lat;
      int rd_before;
      int all_before;
      rd_before = rd_bursts;
      all_before = rd_bursts + wr_bursts;
      run_cmd(addr, 4'h0, 32'h0, got, lat);
      check_val("rsp_rdata", got, shadow_word(addr));
      if (kind == want_hit) begin
         check_val("rsp_valid latency", lat, 1);
         check_val("SDRAM bursts on hit", rd_bursts + wr_bursts - all_before, 0);
      end else if (kind == want_miss) begin
         check_val("sdr_rd_req bursts", rd_bursts - rd_before, 1);
      end
   endtask

   // SDRAM copy of a line against the shadow
   task automatic line_check(input int base);
      int a;
      for (int h = 0; h < `L2_BURST_LEN; h++) begin
         a = base + 2 * h;
         check_val("sdram halfword", u_sdram.read_half(a >> 1),
                   {shadow_byte(a + 1), shadow_byte(a)});
      end
   endtask

   task automatic run_flush();
      flush_req <= 1'b1;
      @(posedge clk);
      flush_req <= 1'b0;
      @(posedge clk);
      check_val("flush_busy", flush_busy, 1);
      while (flush_busy)
         @(posedge clk);
   endtask

   initial begin
      watchdog_wait();
   end

   task automatic watchdog_wait();
      #(watchdog_cycles * clk_period);
      stop_run("watchdog expired before the tests finished");
   endtask

   initial begin
      int wr_before;
      int line_base;
      int addr;
      void'($urandom(64505));
      rst_n = 1'b0;
      cmd_valid = 1'b0;
      cmd_addr = '0;
      cmd_we_msk = '0;
      cmd_wdata = '0;
      rsp_ready = 1'b1;
      flush_req = 1'b0;
      bp_mode = 1'b0;
      repeat (16) @(posedge clk);
      rst_n <= 1'b1;
      @(posedge clk);

      check_val("cmd_ready", cmd_ready, 1);
      check_val("rsp_valid", rsp_valid, 0);
      check_val("flush_busy", flush_busy, 0);
      check_val("sdr_rd_req", sdr_rd_req, 0);
      check_val("sdr_wr_req", sdr_wr_req, 0);

      // Set 0, tag 5
      read_check('h508, want_miss);
      read_check('h510, want_hit);
      // Byte lanes 1 and 2 only
      write_cmd('h508, 4'b0110, 32'ha5c3_7e19);
      read_check('h508, want_hit);

      // Five tags in set 1; the fifth evicts the first
      wr_before = wr_bursts;
      for (int t = 0; t < 5; t++)
         write_cmd((t + 16) * 256 + 64 + 12, 4'hf, $urandom);
      check_val("write bursts", wr_bursts - wr_before, 1);
      check_val("sdr_addr", last_wr_addr, (16 * 256 + 64) >> 1);
      line_check(16 * 256 + 64);
      read_check(16 * 256 + 64 + 12, want_miss);

      run_flush();
      foreach (written_lines[i])
         line_check(written_lines[i]);
      read_check('h508, want_miss);

      // Random rsp_ready over two lines
      bp_mode = 1'b1;
      for (int n = 0; n < 10; n++) begin
         line_base = (n % 2 == 1) ? 'h780 : 'h500;
         addr = line_base + 4 * ($urandom % 16);
         if ($urandom % 2 == 1)
            write_cmd(addr, 4'($urandom), $urandom);
         else
            read_check(addr, any_rsp);
      end
      bp_mode = 1'b0;

      if (stall_cycles == 0) begin
         stop_run("back-pressure was never applied to a response");
      end else begin
         $display("all tests passed");
         $finish;
      end
   end

endmodule

// ==== design/l2_cache_burst_port.sv ====
//////////////////////////////
// L2 cache SDRAM burst engine
// Beat counter, halfword packing
//////////////////////////////
`include "l2_cache_consts.svh"

module l2_cache_burst_port (
   input  logic                                    clk,
   input  logic                                    rst_n,
   input  l2_cache_pkg::l2_burst_op_e              burst_op,
   input  logic [`L2_AW-`L2_LINE_BITS-1:0]         burst_line_addr,
   input  logic [`L2_WAY_BITS+`L2_SET_BITS-1:0]    burst_way_set,
   output logic                                    burst_done,
   output logic                                    ram_en,
   output logic [`L2_RAM_AW-1:0]                   ram_addr,
   output logic [`L2_DW/8-1:0]                     ram_we,
   output logic [`L2_DW-1:0]                       ram_wdata,
   input  logic [`L2_DW-1:0]                       ram_rdata,
   output logic                                    sdr_rd_req,
   output logic                                    sdr_wr_req,
   output logic [`L2_AW-2:0]                       sdr_addr,
   input  logic [`L2_SDR_DW-1:0]                   sdr_rdata,
   input  logic                                    sdr_r_vld,
   output logic [`L2_SDR_DW-1:0]                   sdr_wdata,
   input  logic                                    sdr_w_rdy
);
   import l2_cache_pkg::*;

   localparam int CW = $clog2(`L2_BURST_LEN);

   logic [CW-1:0] beat_cnt;
   logic [CW-2:0] word;
   logic          start;
   logic          rd_beat;
   logic          wr_beat;

   // Hold off for the done cycle, when burst_op has not yet moved on
   assign start = (burst_op != op_none) && !sdr_rd_req && !sdr_wr_req && !burst_done;
   assign rd_beat = sdr_rd_req && sdr_r_vld;
   assign wr_beat = sdr_wr_req && sdr_w_rdy;

   // Writes fetch word 0 at start, then the next word as each high half leaves
   assign word = sdr_wr_req ? beat_cnt[CW-1:1] + 1'b1 : beat_cnt[CW-1:1];
   assign ram_en = rd_beat || (wr_beat && beat_cnt[0]) ||
                   (start && burst_op == op_write_line);
   assign ram_addr = {burst_way_set, word};

   // Even beats fill the low halfword, odd beats the high one
   assign ram_we = rd_beat ? (beat_cnt[0] ? 4'b1100 : 4'b0011) : 4'b0000;
   assign ram_wdata = {sdr_rdata, sdr_rdata};
   assign sdr_wdata = beat_cnt[0] ? ram_rdata[31:16] : ram_rdata[15:0];
   assign sdr_addr = {burst_line_addr, {CW{1'b0}}};

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         sdr_rd_req <= 1'b0;
         sdr_wr_req <= 1'b0;
         beat_cnt <= '0;
         burst_done <= 1'b0;
      end else begin
         burst_done <= 1'b0;
         if (start) begin
            sdr_rd_req <= (burst_op == op_read_line);
            sdr_wr_req <= (burst_op == op_write_line);
         end else if (rd_beat || wr_beat) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (beat_cnt == CW'(`L2_BURST_LEN - 1)) begin
               sdr_rd_req <= 1'b0;
               sdr_wr_req <= 1'b0;
               burst_done <= 1'b1;
            end
         end
      end
   end

   a_one_req: assert property (@(posedge clk) disable iff (!rst_n)
      !(sdr_rd_req && sdr_wr_req));

endmodule

// ==== design/l2_cache_ctrl.sv ====
//////////////////////////////
// L2 cache controller
// Command handshake, miss FSM
// Flush walk
//////////////////////////////
`include "l2_cache_consts.svh"

module l2_cache_ctrl (
   input  logic                                    clk,
   input  logic                                    rst_n,
   input  logic                                    cmd_valid,
   output logic                                    cmd_ready,
   input  logic [`L2_AW-1:0]                       cmd_addr,
   input  logic [`L2_DW/8-1:0]                     cmd_we_msk,
   input  logic [`L2_DW-1:0]                       cmd_wdata,
   output logic                                    rsp_valid,
   input  logic                                    rsp_ready,
   input  logic                                    flush_req,
   output logic                                    flush_busy,
   output logic                                    lookup_en,
   output logic [`L2_SET_BITS-1:0]                 lookup_set,
   output logic [`L2_TAG_BITS-1:0]                 lookup_tag,
   output logic                                    wr_hit,
   output logic                                    fill_en,
   output logic [`L2_WAY_BITS-1:0]                 flush_way,
   input  logic                                    hit,
   input  logic [`L2_WAY_BITS-1:0]                 hit_way,
   input  logic [`L2_WAY_BITS-1:0]                 victim_way,
   input  logic                                    victim_dirty,
   input  logic [`L2_TAG_BITS-1:0]                 victim_tag,
   output logic                                    cpu_en,
   output logic [`L2_RAM_AW-1:0]                   cpu_addr,
   output logic [`L2_DW/8-1:0]                     cpu_we,
   output logic [`L2_DW-1:0]                       cpu_wdata,
   output l2_cache_pkg::l2_burst_op_e              burst_op,
   output logic [`L2_AW-`L2_LINE_BITS-1:0]         burst_line_addr,
   output logic [`L2_WAY_BITS+`L2_SET_BITS-1:0]    burst_way_set,
   input  logic                                    burst_done
);
   import l2_cache_pkg::*;

   localparam int LB = `L2_LINE_BITS;
   localparam int SB = `L2_SET_BITS;

   l2_state_e                       state;
   logic                            pend;
   logic [`L2_AW-1:0]               addr_r;
   logic [`L2_DW/8-1:0]             msk_r;
   logic [`L2_DW-1:0]               wdata_r;
   logic [`L2_WAY_BITS+SB-1:0]      flush_cnt;
   logic [`L2_AW-1:0]               cur_addr;
   logic [`L2_DW/8-1:0]             cur_msk;
   logic                            accept;
   logic                            active;
   logic                            flush_go;

   assign cmd_ready = !pend && !flush_busy;
   assign accept = cmd_valid && cmd_ready;
   assign flush_busy = (state == st_flush_step);
   // Commands win over a flush request in the same cycle
   assign flush_go = flush_req && state == st_idle && !pend && !cmd_valid;

   // Look up the incoming command directly so a hit answers next cycle
   assign cur_addr = pend ? addr_r : cmd_addr;
   assign cur_msk = pend ? msk_r : cmd_we_msk;
   assign active = (state == st_idle) && (accept || (pend && !rsp_valid));

   assign lookup_en = active;
   assign lookup_set = flush_busy ? flush_cnt[SB-1:0] : cur_addr[LB+SB-1:LB];
   assign lookup_tag = cur_addr[`L2_AW-1:LB+SB];
   assign wr_hit = |cur_msk;
   assign flush_way = flush_cnt[`L2_WAY_BITS+SB-1:SB];

   assign cpu_en = active && hit;
   assign cpu_addr = {hit_way, lookup_set, cur_addr[LB-1:2]};
   assign cpu_we = cur_msk;
   assign cpu_wdata = pend ? wdata_r : cmd_wdata;

   // Refill installs the tag; each flush entry is invalidated once clean
   assign fill_en = (state == st_refill && burst_done) ||
                    (state == st_flush_step && (!victim_dirty || burst_done));

   always_comb begin
      case (state)
         st_write_back: burst_op = op_write_line;
         st_refill:     burst_op = op_read_line;
         st_flush_step: burst_op = victim_dirty ? op_write_line : op_none;
         default:       burst_op = op_none;
      endcase
   end

   assign burst_line_addr = (state == st_refill) ? addr_r[`L2_AW-1:LB] : {victim_tag, lookup_set};
   assign burst_way_set = {victim_way, lookup_set};

   always_ff @(posedge clk) begin
      if (accept) begin
         addr_r <= cmd_addr;
         msk_r <= cmd_we_msk;
         wdata_r <= cmd_wdata;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= st_idle;
         pend <= 1'b0;
         rsp_valid <= 1'b0;
         flush_cnt <= '0;
      end else begin
         if (rsp_valid && rsp_ready) begin
            rsp_valid <= 1'b0;
            pend <= 1'b0;
         end
         case (state)
            st_idle: begin
               if (active) begin
                  pend <= 1'b1;
                  if (hit)
                     rsp_valid <= 1'b1;
                  else if (victim_dirty)
                     state <= st_write_back;
                  else
                     state <= st_refill;
               end else if (flush_go) begin
                  state <= st_flush_step;
               end
            end
            st_write_back: begin
               if (burst_done)
                  state <= st_refill;
            end
            // Back to idle, where the lookup is replayed and now hits
            st_refill: begin
               if (burst_done)
                  state <= st_idle;
            end
            st_flush_step: begin
               // Counter wraps to zero after the last entry
               if (fill_en) begin
                  flush_cnt <= flush_cnt + 1'b1;
                  if (&flush_cnt)
                     state <= st_idle;
               end
            end
            default: state <= st_idle;
         endcase
      end
   end

   // Memory port stays idle while a response waits, holding rsp_rdata
   a_rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
      rsp_valid && !rsp_ready |-> !cpu_en ##1 rsp_valid);

endmodule

// ==== design/l2_cache_data_ram.sv ====
//////////////////////////////
// L2 cache line data memory
// Two byte-enabled ports
//////////////////////////////
`include "l2_cache_consts.svh"

module l2_cache_data_ram (
   input  logic                   clk,
   input  logic                   cpu_en,
   input  logic [`L2_RAM_AW-1:0]  cpu_addr,
   input  logic [`L2_DW/8-1:0]    cpu_we,
   input  logic [`L2_DW-1:0]      cpu_wdata,
   output logic [`L2_DW-1:0]      cpu_rdata,
   input  logic                   bus_en,
   input  logic [`L2_RAM_AW-1:0]  bus_addr,
   input  logic [`L2_DW/8-1:0]    bus_we,
   input  logic [`L2_DW-1:0]      bus_wdata,
   output logic [`L2_DW-1:0]      bus_rdata
);
   // Word index is {way, set, word in line}
   logic [`L2_DW-1:0] mem [1 << `L2_RAM_AW];

   always_ff @(posedge clk) begin
      if (cpu_en) begin
         for (int b = 0; b < `L2_DW/8; b++) begin
            if (cpu_we[b])
               mem[cpu_addr][8*b +: 8] <= cpu_wdata[8*b +: 8];
         end
         cpu_rdata <= mem[cpu_addr];
      end
      if (bus_en) begin
         for (int b = 0; b < `L2_DW/8; b++) begin
            if (bus_we[b])
               mem[bus_addr][8*b +: 8] <= bus_wdata[8*b +: 8];
         end
         bus_rdata <= mem[bus_addr];
      end
   end

endmodule

// ==== design/l2_cache_pkg.sv ====
//////////////////////////////
// L2 cache shared types
// Controller states, burst opcodes
//////////////////////////////
package l2_cache_pkg;

   // Main controller states
   typedef enum logic [2:0] {
      // Serving hits, waiting for commands
      st_idle,
      // Dirty victim going out to SDRAM
      st_write_back,
      // Line coming in from SDRAM
      st_refill,
      // One entry of the flush walk
      st_flush_step
   } l2_state_e;

   // Request from controller to burst engine
   typedef enum logic [1:0] {
      op_none,
      // SDRAM to line memory
      op_read_line,
      // Line memory to SDRAM
      op_write_line
   } l2_burst_op_e;

endpackage

// ==== design/l2_cache_tag_store.sv ====
//////////////////////////////
// L2 cache tag store
// Valid, dirty, tag and LRU arrays
// Hit and victim lookup
//////////////////////////////
`include "l2_cache_consts.svh"

module l2_cache_tag_store (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      lookup_en,
   input  logic [`L2_SET_BITS-1:0]   lookup_set,
   input  logic [`L2_TAG_BITS-1:0]   lookup_tag,
   input  logic                      wr_hit,
   input  logic                      fill_en,
   input  logic [`L2_WAY_BITS-1:0]   flush_way,
   input  logic                      flush_mode,
   output logic                      hit,
   output logic [`L2_WAY_BITS-1:0]   hit_way,
   output logic [`L2_WAY_BITS-1:0]   victim_way,
   output logic                      victim_dirty,
   output logic [`L2_TAG_BITS-1:0]   victim_tag
);
   localparam int WB = `L2_WAY_BITS;
   localparam int WAYS = 1 << `L2_WAY_BITS;
   localparam int SETS = 1 << `L2_SET_BITS;

   logic                    valid_q [WAYS][SETS];
   logic                    dirty_q [WAYS][SETS];
   logic [`L2_TAG_BITS-1:0] tag_q [WAYS][SETS];
   logic [WB-1:0]           lru_q [WAYS][SETS];
   logic [WAYS-1:0]         match;
   logic [WB-1:0]           lru_way;
   logic [WB-1:0]           hit_rank;

   // Compare all ways at once; rank 0 is least recently used
   always_comb begin
      match = '0;
      hit_way = '0;
      lru_way = '0;
      for (int w = 0; w < WAYS; w++) begin
         match[w] = valid_q[w][lookup_set] && (tag_q[w][lookup_set] == lookup_tag)
                    && !flush_mode;
         if (match[w])
            hit_way = WB'(w);
         if (lru_q[w][lookup_set] == '0)
            lru_way = WB'(w);
      end
   end

   assign hit = |match;
   assign victim_way = flush_mode ? flush_way : lru_way;
   assign victim_dirty = dirty_q[victim_way][lookup_set];
   assign victim_tag = tag_q[victim_way][lookup_set];
   assign hit_rank = lru_q[hit_way][lookup_set];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int w = 0; w < WAYS; w++) begin
            for (int s = 0; s < SETS; s++) begin
               valid_q[w][s] <= 1'b0;
               dirty_q[w][s] <= 1'b0;
               lru_q[w][s] <= WB'(w);
            end
         end
      end else begin
         if (lookup_en && hit) begin
            // Hit way becomes most recent, ways above its old rank move down
            for (int w = 0; w < WAYS; w++) begin
               if (WB'(w) == hit_way)
                  lru_q[w][lookup_set] <= '1;
               else if (lru_q[w][lookup_set] > hit_rank)
                  lru_q[w][lookup_set] <= lru_q[w][lookup_set] - 1'b1;
            end
            if (wr_hit)
               dirty_q[hit_way][lookup_set] <= 1'b1;
         end
         // Fill validates, flush invalidates; both leave the line clean
         if (fill_en) begin
            valid_q[victim_way][lookup_set] <= !flush_mode;
            dirty_q[victim_way][lookup_set] <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (fill_en && !flush_mode)
         tag_q[victim_way][lookup_set] <= lookup_tag;
   end

   a_one_hit: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(match));

endmodule

// ==== design/l2_cache_top.sv ====
//////////////////////////////
// L2 cache top level
//////////////////////////////
`include "l2_cache_consts.svh"

module l2_cache_top (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     cmd_valid,
   output logic                     cmd_ready,
   input  logic [`L2_AW-1:0]        cmd_addr,
   input  logic [`L2_DW/8-1:0]      cmd_we_msk,
   input  logic [`L2_DW-1:0]        cmd_wdata,
   output logic                     rsp_valid,
   input  logic                     rsp_ready,
   output logic [`L2_DW-1:0]        rsp_rdata,
   input  logic                     flush_req,
   output logic                     flush_busy,
   output logic                     sdr_rd_req,
   output logic                     sdr_wr_req,
   output logic [`L2_AW-2:0]        sdr_addr,
   input  logic [`L2_SDR_DW-1:0]    sdr_rdata,
   input  logic                     sdr_r_vld,
   output logic [`L2_SDR_DW-1:0]    sdr_wdata,
   input  logic                     sdr_w_rdy
);
   import l2_cache_pkg::*;

   logic                                   lookup_en;
   logic [`L2_SET_BITS-1:0]                lookup_set;
   logic [`L2_TAG_BITS-1:0]                lookup_tag;
   logic                                   wr_hit;
   logic                                   fill_en;
   logic [`L2_WAY_BITS-1:0]                flush_way;
   logic                                   hit;
   logic [`L2_WAY_BITS-1:0]                hit_way;
   logic [`L2_WAY_BITS-1:0]                victim_way;
   logic                                   victim_dirty;
   logic [`L2_TAG_BITS-1:0]                victim_tag;
   logic                                   cpu_en;
   logic [`L2_RAM_AW-1:0]                  cpu_addr;
   logic [`L2_DW/8-1:0]                    cpu_we;
   logic [`L2_DW-1:0]                      cpu_wdata;
   l2_burst_op_e                           burst_op;
   logic [`L2_AW-`L2_LINE_BITS-1:0]        burst_line_addr;
   logic [`L2_WAY_BITS+`L2_SET_BITS-1:0]   burst_way_set;
   logic                                   burst_done;
   logic                                   bus_en;
   logic [`L2_RAM_AW-1:0]                  bus_addr;
   logic [`L2_DW/8-1:0]                    bus_we;
   logic [`L2_DW-1:0]                      bus_wdata;
   logic [`L2_DW-1:0]                      bus_rdata;

   l2_cache_ctrl u_ctrl (
      .clk             (clk),
      .rst_n           (rst_n),
      .cmd_valid       (cmd_valid),
      .cmd_ready       (cmd_ready),
      .cmd_addr        (cmd_addr),
      .cmd_we_msk      (cmd_we_msk),
      .cmd_wdata       (cmd_wdata),
      .rsp_valid       (rsp_valid),
      .rsp_ready       (rsp_ready),
      .flush_req       (flush_req),
      .flush_busy      (flush_busy),
      .lookup_en       (lookup_en),
      .lookup_set      (lookup_set),
      .lookup_tag      (lookup_tag),
      .wr_hit          (wr_hit),
      .fill_en         (fill_en),
      .flush_way       (flush_way),
      .hit             (hit),
      .hit_way         (hit_way),
      .victim_way      (victim_way),
      .victim_dirty    (victim_dirty),
      .victim_tag      (victim_tag),
      .cpu_en          (cpu_en),
      .cpu_addr        (cpu_addr),
      .cpu_we          (cpu_we),
      .cpu_wdata       (cpu_wdata),
      .burst_op        (burst_op),
      .burst_line_addr (burst_line_addr),
      .burst_way_set   (burst_way_set),
      .burst_done      (burst_done)
   );

   // Flush walk drives the tag store's flush mode
   l2_cache_tag_store u_tags (
      .clk          (clk),
      .rst_n        (rst_n),
      .lookup_en    (lookup_en),
      .lookup_set   (lookup_set),
      .lookup_tag   (lookup_tag),
      .wr_hit       (wr_hit),
      .fill_en      (fill_en),
      .flush_way    (flush_way),
      .flush_mode   (flush_busy),
      .hit          (hit),
      .hit_way      (hit_way),
      .victim_way   (victim_way),
      .victim_dirty (victim_dirty),
      .victim_tag   (victim_tag)
   );

   l2_cache_data_ram u_ram (
      .clk       (clk),
      .cpu_en    (cpu_en),
      .cpu_addr  (cpu_addr),
      .cpu_we    (cpu_we),
      .cpu_wdata (cpu_wdata),
      .cpu_rdata (rsp_rdata),
      .bus_en    (bus_en),
      .bus_addr  (bus_addr),
      .bus_we    (bus_we),
      .bus_wdata (bus_wdata),
      .bus_rdata (bus_rdata)
   );

   l2_cache_burst_port u_burst (
      .clk             (clk),
      .rst_n           (rst_n),
      .burst_op        (burst_op),
      .burst_line_addr (burst_line_addr),
      .burst_way_set   (burst_way_set),
      .burst_done      (burst_done),
      .ram_en          (bus_en),
      .ram_addr        (bus_addr),
      .ram_we          (bus_we),
      .ram_wdata       (bus_wdata),
      .ram_rdata       (bus_rdata),
      .sdr_rd_req      (sdr_rd_req),
      .sdr_wr_req      (sdr_wr_req),
      .sdr_addr        (sdr_addr),
      .sdr_rdata       (sdr_rdata),
      .sdr_r_vld       (sdr_r_vld),
      .sdr_wdata       (sdr_wdata),
      .sdr_w_rdy       (sdr_w_rdy)
   );

endmodule

// ==== include/l2_cache_consts.svh ====
//////////////////////////////
// L2 cache geometry and bus widths
// Derived tag and memory address widths
//////////////////////////////
`ifndef L2_CACHE_CONSTS_SVH
`define L2_CACHE_CONSTS_SVH

// Log2 of ways, sets and bytes per line
`define L2_WAY_BITS 2
`define L2_SET_BITS 2
`define L2_LINE_BITS 6

// Byte address, processor data and SDRAM beat widths
`define L2_AW 25
`define L2_DW 32
`define L2_SDR_DW 16

// Halfword beats in one line burst
`define L2_BURST_LEN 32

`define L2_TAG_BITS (`L2_AW - `L2_SET_BITS - `L2_LINE_BITS)
`define L2_WORD_BITS (`L2_LINE_BITS - 2)
`define L2_RAM_AW (`L2_WAY_BITS + `L2_SET_BITS + `L2_WORD_BITS)

`endif

// ==== tb.f ====
+incdir+include
design/l2_cache_pkg.sv
design/l2_cache_tag_store.sv
design/l2_cache_data_ram.sv
design/l2_cache_ctrl.sv
design/l2_cache_burst_port.sv
design/l2_cache_top.sv
bench/sdram_burst_model.sv
bench/tb_l2_cache.sv
